/* include/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// TLB geometry
`define MMU_TLB_ENTRIES 16
`define MMU_TLB_IDX_W   4

// CRMD fields
`define MMU_CRMD_PLV  1:0
`define MMU_CRMD_DA   3
`define MMU_CRMD_PG   4
`define MMU_CRMD_DATF 6:5
`define MMU_CRMD_DATM 8:7

// DMW fields
`define MMU_DMW_PLV0 0
`define MMU_DMW_PLV3 3
`define MMU_DMW_MAT  5:4
`define MMU_DMW_PSEG 27:25
`define MMU_DMW_VSEG 31:29

`endif

/* src/mmu_pkg.sv */
`include "mmu_config.svh"

package mmu_pkg;

  typedef struct packed {
    logic [8:0]  crmd;
    logic [9:0]  asid;
    logic [31:0] dmw0;
    logic [31:0] dmw1;
  } mmu_csr_t;

  // Lookup key of one entry
  typedef struct packed {
    logic [18:0] vppn;
    logic [5:0]  ps;
    logic        g;
    logic [9:0]  asid;
    logic        e;
  } tlb_key_t;

  // One page of an even/odd pair
  typedef struct packed {
    logic [19:0] ppn;
    logic [1:0]  plv;
    logic [1:0]  mat;
    logic        d;
    logic        v;
  } tlb_value_t;

  typedef struct packed {
    logic                      we;
    logic [`MMU_TLB_IDX_W-1:0] idx;
    tlb_key_t                  key;
    tlb_value_t [1:0]          value;
  } tlb_update_req_t;

  // Stage one to stage two record
  typedef struct packed {
    logic                      found;
    logic                      dmw;
    logic [`MMU_TLB_IDX_W-1:0] index;
    logic [5:0]                ps;
    tlb_value_t                value;
    logic [31:0]               vaddr;
  } trans_result_t;

  typedef enum logic [2:0] {
    EXC_NONE    = 3'd0,
    EXC_REFILL  = 3'd1,
    EXC_INVALID = 3'd2,
    EXC_PRIV    = 3'd3,
    EXC_MODIFY  = 3'd4
  } trans_exc_e;

endpackage

/* src/tlb_entry_match.sv */
`timescale 1ns/1ps

module tlb_entry_match (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              update_i,
  input  mmu_pkg::tlb_key_t update_key_i,
  input  logic [31:0]       vaddr_i,
  input  logic [9:0]        asid_i,
  output logic              match_o,
  output logic              is_4m_o
);
  import mmu_pkg::*;

  tlb_key_t key_q;
  logic     e_q;
  logic     vppn_hi_eq;
  logic     vppn_lo_eq;
  logic     asid_ok;

  // Entry exists bit
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      e_q <= 1'b0;
    end else if (update_i) begin
      e_q <= update_key_i.e;
    end
  end

  always_ff @(posedge clk) begin
    if (update_i) begin
      key_q <= update_key_i;
    end
  end

  assign is_4m_o = key_q.ps == 6'd22;

  // Low vppn bits fall inside a 4 MB page
  assign vppn_hi_eq = key_q.vppn[18:10] == vaddr_i[31:23];
  assign vppn_lo_eq = key_q.vppn[9:0] == vaddr_i[22:13];
  assign asid_ok    = key_q.g || (key_q.asid == asid_i);

  assign match_o = e_q && asid_ok && vppn_hi_eq && (is_4m_o || vppn_lo_eq);

endmodule

/* src/addr_trans_stage.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module addr_trans_stage #(
  parameter bit FETCH_ADDR = 1'b0
) (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     valid_i,
  input  logic                     store_i,
  input  logic [31:0]              vaddr_i,
  input  logic                     stall_i,
  input  mmu_pkg::mmu_csr_t        csr_i,
  input  mmu_pkg::tlb_update_req_t tlb_update_i,
  output mmu_pkg::trans_result_t   result_o,
  output logic                     valid_o,
  output logic                     store_o,
  output logic [1:0]               plv_o
);
  import mmu_pkg::*;

  localparam int ENTRIES = `MMU_TLB_ENTRIES;
  localparam int IDX_W   = `MMU_TLB_IDX_W;

  logic [ENTRIES-1:0] entry_we;
  logic [ENTRIES-1:0] match;
  logic [ENTRIES-1:0] is_4m;
  tlb_value_t [1:0]   value_q [ENTRIES];

  logic          da_mode;
  logic [1:0]    cur_plv;
  logic          dmw0_hit;
  logic          dmw1_hit;
  trans_result_t tlb_res;
  trans_result_t da_res;
  trans_result_t dmw0_res;
  trans_result_t dmw1_res;
  trans_result_t sel_res;

  trans_result_t result_q;
  logic          valid_q;
  logic          store_q;
  logic [1:0]    plv_q;

  function automatic logic dmw_hit_f(logic [31:0] dmw, logic [31:0] va, logic [1:0] plv);
    logic plv_ok;
    plv_ok = (dmw[`MMU_DMW_PLV0] && plv == 2'd0) || (dmw[`MMU_DMW_PLV3] && plv == 2'd3);
    return plv_ok && (va[31:29] == dmw[`MMU_DMW_VSEG]);
  endfunction

  // Window hit looks like a 4 KB page with full rights
  function automatic trans_result_t dmw_res_f(logic [31:0] dmw, logic [31:0] va);
    trans_result_t r;
    r           = '0;
    r.found     = 1'b1;
    r.dmw       = 1'b1;
    r.ps        = 6'd12;
    r.value.ppn = {dmw[`MMU_DMW_PSEG], va[28:12]};
    r.value.plv = 2'd3;
    r.value.mat = dmw[`MMU_DMW_MAT];
    r.value.d   = 1'b1;
    r.value.v   = 1'b1;
    r.vaddr     = va;
    return r;
  endfunction

  for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
    assign entry_we[i] = tlb_update_i.we && (tlb_update_i.idx == IDX_W'(i));

    tlb_entry_match u_match (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .update_i     (entry_we[i]),
      .update_key_i (tlb_update_i.key),
      .vaddr_i      (vaddr_i),
      .asid_i       (csr_i.asid),
      .match_o      (match[i]),
      .is_4m_o      (is_4m[i])
    );
  end

  // Even/odd page pairs
  always_ff @(posedge clk) begin
    if (tlb_update_i.we) begin
      value_q[tlb_update_i.idx] <= tlb_update_i.value;
    end
  end

  // At most one entry matches, so OR the hits together
  always_comb begin
    tlb_value_t page;
    tlb_res       = '0;
    tlb_res.vaddr = vaddr_i;
    for (int i = 0; i < ENTRIES; i++) begin
      page = value_q[i][is_4m[i] ? vaddr_i[22] : vaddr_i[12]];
      if (match[i]) begin
        tlb_res.found = 1'b1;
        tlb_res.index |= IDX_W'(i);
        tlb_res.ps    |= is_4m[i] ? 6'd22 : 6'd12;
        tlb_res.value |= page;
      end
    end
  end

  assign da_mode = csr_i.crmd[`MMU_CRMD_DA];
  assign cur_plv = csr_i.crmd[`MMU_CRMD_PLV];

  always_comb begin
    da_res           = '0;
    da_res.found     = 1'b1;
    da_res.dmw       = 1'b1;
    da_res.ps        = 6'd12;
    da_res.value.ppn = vaddr_i[31:12];
    da_res.value.plv = 2'd3;
    da_res.value.mat = FETCH_ADDR ? csr_i.crmd[`MMU_CRMD_DATF] : csr_i.crmd[`MMU_CRMD_DATM];
    da_res.value.d   = 1'b1;
    da_res.value.v   = 1'b1;
    da_res.vaddr     = vaddr_i;
  end

  assign dmw0_hit = dmw_hit_f(csr_i.dmw0, vaddr_i, cur_plv);
  assign dmw1_hit = dmw_hit_f(csr_i.dmw1, vaddr_i, cur_plv);
  assign dmw0_res = dmw_res_f(csr_i.dmw0, vaddr_i);
  assign dmw1_res = dmw_res_f(csr_i.dmw1, vaddr_i);

  // DA first, then window 0, window 1, TLB
  always_comb begin
    if (da_mode) begin
      sel_res = da_res;
    end else if (dmw0_hit) begin
      sel_res = dmw0_res;
    end else if (dmw1_hit) begin
      sel_res = dmw1_res;
    end else begin
      sel_res = tlb_res;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      result_q <= sel_res;
      store_q  <= store_i;
      plv_q    <= cur_plv;
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;
  assign store_o  = store_q;
  assign plv_o    = plv_q;

endmodule

/* src/phys_addr_stage.sv */
`timescale 1ns/1ps

module phys_addr_stage (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   valid_i,
  input  logic                   store_i,
  input  logic [1:0]             plv_i,
  input  mmu_pkg::trans_result_t result_i,
  input  logic                   stall_i,
  output logic                   valid_o,
  output logic [31:0]            paddr_o,
  output logic [1:0]             mat_o,
  output mmu_pkg::trans_exc_e    exc_o
);
  import mmu_pkg::*;

  logic [31:0] paddr;
  trans_exc_e  exc;

  logic        valid_q;
  logic [31:0] paddr_q;
  logic [1:0]  mat_q;
  trans_exc_e  exc_q;

  // Page offset width follows the page size
  always_comb begin
    if (result_i.ps == 6'd22) begin
      paddr = {result_i.value.ppn[19:10], result_i.vaddr[21:0]};
    end else begin
      paddr = {result_i.value.ppn, result_i.vaddr[11:0]};
    end
  end

  always_comb begin
    if (!result_i.found) begin
      exc = EXC_REFILL;
    end else if (!result_i.value.v) begin
      exc = EXC_INVALID;
    end else if (plv_i > result_i.value.plv) begin
      exc = EXC_PRIV;
    end else if (store_i && !result_i.value.d) begin
      exc = EXC_MODIFY;
    end else begin
      exc = EXC_NONE;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      paddr_q <= paddr;
      mat_q   <= result_i.value.mat;
      exc_q   <= exc;
    end
  end

  assign valid_o = valid_q;
  assign paddr_o = paddr_q;
  assign mat_o   = mat_q;
  assign exc_o   = exc_q;

endmodule

/* src/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     valid_i,
  input  logic [31:0]              vaddr_i,
  input  logic                     store_i,
  input  logic                     stall_i,
  input  mmu_pkg::mmu_csr_t        csr_i,
  input  mmu_pkg::tlb_update_req_t tlb_update_i,
  output logic                     valid_o,
  output logic [31:0]              paddr_o,
  output logic [1:0]               mat_o,
  output mmu_pkg::trans_exc_e      exc_o
);
  import mmu_pkg::*;

  trans_result_t s1_result;
  logic          s1_valid;
  logic          s1_store;
  logic [1:0]    s1_plv;

  // Data-side instance
  addr_trans_stage #(
    .FETCH_ADDR (1'b0)
  ) u_addr_trans (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_i),
    .store_i      (store_i),
    .vaddr_i      (vaddr_i),
    .stall_i      (stall_i),
    .csr_i        (csr_i),
    .tlb_update_i (tlb_update_i),
    .result_o     (s1_result),
    .valid_o      (s1_valid),
    .store_o      (s1_store),
    .plv_o        (s1_plv)
  );

  phys_addr_stage u_phys_addr (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_i  (s1_valid),
    .store_i  (s1_store),
    .plv_i    (s1_plv),
    .result_i (s1_result),
    .stall_i  (stall_i),
    .valid_o  (valid_o),
    .paddr_o  (paddr_o),
    .mat_o    (mat_o),
    .exc_o    (exc_o)
  );

endmodule

/* tb/mmu_asserts.sv */
`timescale 1ns/1ps

module mmu_asserts (
  input logic                clk,
  input logic                arst_n_i,
  input logic                stall_i,
  input logic                valid_o,
  input logic [31:0]         paddr_o,
  input logic [1:0]          mat_o,
  input mmu_pkg::trans_exc_e exc_o
);
  int fail_cnt;

  a_reset_valid: assert property (@(posedge clk) !arst_n_i |-> !valid_o)
    else begin
      fail_cnt++;
      $error("valid_o high while reset is asserted");
    end

  // Registers hold on the stalled edge
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    stall_i && valid_o |=> $stable(valid_o) && $stable(paddr_o) && $stable(mat_o)
      && $stable(exc_o))
    else begin
      fail_cnt++;
      $error("outputs changed while stall_i was high");
    end

  a_exc_known: assert property (@(posedge clk) disable iff (!arst_n_i)
    valid_o |-> !$isunknown(exc_o))
    else begin
      fail_cnt++;
      $error("exc_o unknown with valid_o high");
    end

endmodule

bind mmu_top mmu_asserts u_asserts (.*);

/* tb/mmu_tb.sv */
`timescale 1ns/1ps
`include "mmu_config.svh"

module mmu_tb;
  import mmu_pkg::*;

  typedef struct packed {
    logic [31:0] paddr;
    logic [1:0]  mat;
    trans_exc_e  exc;
  } exp_t;

  localparam logic [9:0] ASID = 10'h155;

  logic            clk = 1'b0;
  logic            arst_n_i;
  logic            valid_i;
  logic [31:0]     vaddr_i;
  logic            store_i;
  logic            stall_i;
  mmu_csr_t        csr_i;
  tlb_update_req_t tlb_update_i;
  logic            valid_o;
  logic [31:0]     paddr_o;
  logic [1:0]      mat_o;
  trans_exc_e      exc_o;

  logic [15:0]      lfsr_q = 16'd5481;
  tlb_key_t         key_m [`MMU_TLB_ENTRIES];
  tlb_value_t [1:0] val_m [`MMU_TLB_ENTRIES];
  exp_t             exp_q [$];
  string            name_q [$];
  int               stamp_q [$];
  string            test_name;
  logic             adv;
  int               adv_cnt = 0;

  mmu_top dut0 (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (valid_i),
    .vaddr_i      (vaddr_i),
    .store_i      (store_i),
    .stall_i      (stall_i),
    .csr_i        (csr_i),
    .tlb_update_i (tlb_update_i),
    .valid_o      (valid_o),
    .paddr_o      (paddr_o),
    .mat_o        (mat_o),
    .exc_o        (exc_o)
  );

  always #50 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic win_hit(logic [31:0] dmw, logic [31:0] a, logic [1:0] plv);
    logic plv_ok;
    plv_ok = (plv == 2'd0) ? dmw[`MMU_DMW_PLV0] : (plv == 2'd3) ? dmw[`MMU_DMW_PLV3] : 1'b0;
    return plv_ok && (a[31:29] == dmw[`MMU_DMW_VSEG]);
  endfunction

  function automatic exp_t ref_translate(logic [31:0] a, logic st, mmu_csr_t c);
    exp_t       e;
    logic [1:0] plv;
    logic       found;
    logic       big;
    tlb_value_t pg;
    plv     = c.crmd[`MMU_CRMD_PLV];
    found   = 1'b1;
    pg      = '0;
    pg.plv  = 2'd3;
    pg.d    = 1'b1;
    pg.v    = 1'b1;
    e.paddr = a;
    if (c.crmd[`MMU_CRMD_DA]) begin
      pg.mat = c.crmd[`MMU_CRMD_DATM];
    end else if (win_hit(c.dmw0, a, plv)) begin
      pg.mat  = c.dmw0[`MMU_DMW_MAT];
      e.paddr = {c.dmw0[`MMU_DMW_PSEG], a[28:0]};
    end else if (win_hit(c.dmw1, a, plv)) begin
      pg.mat  = c.dmw1[`MMU_DMW_MAT];
      e.paddr = {c.dmw1[`MMU_DMW_PSEG], a[28:0]};
    end else begin
      found = 1'b0;
      for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
        big = key_m[i].ps == 6'd22;
        if (key_m[i].e && (key_m[i].g || key_m[i].asid == c.asid) &&
            key_m[i].vppn[18:10] == a[31:23] && (big || key_m[i].vppn[9:0] == a[22:13])) begin
          found   = 1'b1;
          pg      = val_m[i][big ? a[22] : a[12]];
          e.paddr = big ? {pg.ppn[19:10], a[21:0]} : {pg.ppn, a[11:0]};
        end
      end
    end
    e.mat = pg.mat;
    if (!found) begin
      e.exc = EXC_REFILL;
    end else if (!pg.v) begin
      e.exc = EXC_INVALID;
    end else if (plv > pg.plv) begin
      e.exc = EXC_PRIV;
    end else if (st && !pg.d) begin
      e.exc = EXC_MODIFY;
    end else begin
      e.exc = EXC_NONE;
    end
    return e;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic issue(logic [31:0] a, logic st, mmu_csr_t c, logic stl);
    @(posedge clk);
    valid_i         <= 1'b1;
    vaddr_i         <= a;
    store_i         <= st;
    csr_i           <= c;
    stall_i         <= stl;
    tlb_update_i.we <= 1'b0;
    if (!stl) begin
      exp_q.push_back(ref_translate(a, st, c));
      name_q.push_back(test_name);
    end
  endtask

  // Paged mode, no windows, random privilege and store
  task automatic lookup(logic [31:0] a, logic stl);
    mmu_csr_t    c;
    logic [31:0] r;
    r      = rand_bits(3);
    c      = '0;
    c.asid = ASID;
    c.crmd[`MMU_CRMD_PLV] = r[1:0];
    issue(a, r[2], c, stl);
  endtask

  task automatic write_entry(int idx, tlb_key_t k, tlb_value_t [1:0] v);
    @(posedge clk);
    valid_i      <= 1'b0;
    stall_i      <= 1'b0;
    tlb_update_i <= '{we: 1'b1, idx: `MMU_TLB_IDX_W'(idx), key: k, value: v};
    key_m[idx] = k;
    val_m[idx] = v;
  endtask

  task automatic make_entry(int idx, output tlb_key_t k, output tlb_value_t [1:0] v);
    logic [31:0] r;
    r      = rand_bits(32);
    k.vppn = r[18:0];
    // Distinct high tag per entry, so at most one entry matches
    k.vppn[13:10] = idx[3:0];
    k.ps   = r[19] ? 6'd22 : 6'd12;
    k.g    = r[20];
    k.asid = (r[22:21] == 2'd0) ? r[31:22] : ASID;
    k.e    = 1'b1;
    for (int p = 0; p < 2; p++) begin
      r      = rand_bits(32);
      v[p]   = r[25:0];
      v[p].v = r[27:26] != 2'd0;
    end
  endtask

  function automatic logic [31:0] entry_addr(int i);
    logic [31:0] a;
    a = rand_bits(32);
    if (key_m[i].ps == 6'd22) begin
      a[31:23] = key_m[i].vppn[18:10];
    end else begin
      a[31:13] = key_m[i].vppn;
    end
    return a;
  endfunction

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: valid_o never delivered %0d expected results", exp_q.size());
      $display("ERRORS FOUND");
      $fatal(1, "Output timeout");
    end
  endtask

  // Outputs move only on edges without stall
  always @(posedge clk) begin
    adv <= !stall_i;
    if (arst_n_i && !stall_i) begin
      adv_cnt <= adv_cnt + 1;
      // Unstalled edge count at which the request was taken
      if (valid_i) begin
        stamp_q.push_back(adv_cnt + 1);
      end
    end
  end

  always @(negedge clk) begin
    exp_t  e;
    string n;
    int    s;
    if (arst_n_i && adv && valid_o) begin
      if (exp_q.size() == 0 || stamp_q.size() == 0) begin
        $display("valid_o went high with no request outstanding");
        $display("ERRORS FOUND");
        $fatal(1, "Unexpected output");
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        s = stamp_q.pop_front();
        // Second stage registers on the next unstalled edge
        check_val({n, " latency"}, s + 1, adv_cnt);
        check_val({n, " exc"}, 32'(e.exc), 32'(exc_o));
        if (e.exc != EXC_REFILL) begin
          check_val({n, " paddr"}, e.paddr, paddr_o);
          check_val({n, " mat"}, 32'(e.mat), 32'(mat_o));
        end
      end
    end
  end

  initial begin
    mmu_csr_t         c;
    tlb_key_t         k;
    tlb_value_t [1:0] v;
    logic [31:0]      r;
    logic [31:0]      a;
    int               idx;
    arst_n_i     <= 1'b0;
    valid_i      <= 1'b0;
    vaddr_i      <= '0;
    store_i      <= 1'b0;
    stall_i      <= 1'b0;
    csr_i        <= '0;
    tlb_update_i <= '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      key_m[i] = '0;
    end
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;

    test_name = "da_mode";
    for (int n = 0; n < 24; n++) begin
      r      = rand_bits(32);
      c      = '0;
      c.crmd = r[8:0];
      c.crmd[`MMU_CRMD_DA] = 1'b1;
      issue(rand_bits(32), r[9], c, 1'b0);
    end

    // TLB still empty, so a window miss gives a refill
    test_name = "dmw";
    for (int n = 0; n < 40; n++) begin
      r      = rand_bits(32);
      c      = '0;
      c.crmd = r[8:0];
      c.crmd[`MMU_CRMD_DA]  = 1'b0;
      c.crmd[`MMU_CRMD_PLV] = r[9] ? 2'd3 : 2'd0;
      c.dmw0 = rand_bits(32);
      c.dmw1 = rand_bits(32);
      if (r[10]) begin
        c.dmw1[`MMU_DMW_VSEG] = c.dmw0[`MMU_DMW_VSEG];
      end
      a = rand_bits(32);
      if (r[11]) begin
        a[31:29] = r[12] ? c.dmw0[`MMU_DMW_VSEG] : c.dmw1[`MMU_DMW_VSEG];
      end
      issue(a, r[13], c, 1'b0);
    end

    for (idx = 0; idx < `MMU_TLB_ENTRIES; idx++) begin
      make_entry(idx, k, v);
      write_entry(idx, k, v);
    end
    test_name = "tlb_hit";
    for (int n = 0; n < 80; n++) begin
      lookup((rand_bits(3) != 0) ? entry_addr(rand_bits(4)) : rand_bits(32), 1'b0);
    end

    test_name = "stall";
    for (int n = 0; n < 100; n++) begin
      lookup(entry_addr(rand_bits(4)), rand_bits(2) == 0);
    end

    test_name = "update_order";
    for (int n = 0; n < 16; n++) begin
      idx = rand_bits(4);
      make_entry(idx, k, v);
      write_entry(idx, k, v);
      lookup(entry_addr(idx), 1'b0);
    end

    @(posedge clk);
    valid_i <= 1'b0;
    stall_i <= 1'b0;
    wait_drain();
    if (dut0.u_asserts.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("%0d assertion failures", dut0.u_asserts.fail_cnt);
      $display("ERRORS FOUND");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

/* compile.f */
+incdir+include
src/mmu_pkg.sv
src/tlb_entry_match.sv
src/addr_trans_stage.sv
src/phys_addr_stage.sv
src/mmu_top.sv
tb/mmu_asserts.sv
tb/mmu_tb.sv
